// ==== Makefile ====
SRCS := $(wildcard logic/*.sv verification/*.sv include/*.svh)

.PHONY: run clean

run: obj_dir/Vid_stage_tb
	./obj_dir/Vid_stage_tb | tee sim.log
	grep -q "TEST PASS" sim.log

obj_dir/Vid_stage_tb: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module id_stage_tb

clean:
	rm -rf obj_dir sim.log

// ==== include/id_cfg.svh ====
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

`define ID_XLEN   32
`define ID_NREGS  32
`define ID_RIDX_W 5

`endif

// ==== logic/id_decoder.sv ====
`include "id_cfg.svh"

module id_decoder (
    input  isa_pkg::inst_u inst,
    input  logic           valid,
    decode_if.dec          dec
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [5:0]  op6;
    logic [19:0] si20;
    logic [15:0] si16;
    logic [25:0] si26;
    logic        r3, sh, si12, ui12, sys, brk;
    logic        ld, st, lu12i, pcadd, cond_br, hit;
    alu_op_t     alu;
    dec_bundle_t bnd;

    assign op17  = inst.r3.op;
    assign op10  = inst.ri12.op;
    assign op6   = op17[16:11];
    assign si20  = {op10[2:0], inst.ri12.imm, inst.ri12.rj};
    assign si16  = {op10[3:0], inst.ri12.imm};
    assign si26  = {inst.ri12.rj, inst.ri12.rd, si16};  // upper ten bits sit at the bottom
    assign ld    = op10 inside {op_ld_b, op_ld_h, op_ld_w, op_ld_bu, op_ld_hu};
    assign st    = op10 inside {op_st_b, op_st_h, op_st_w};
    assign lu12i = op17[16:10] == op_lu12i_w;
    assign pcadd = op17[16:10] == op_pcaddu12i;

    always_comb begin
        {r3, sh, si12, ui12, sys, brk} = '0;
        alu = '0;
        case (op17)
            op_add_w:   {r3, alu} = {1'b1, alu_add};
            op_sub_w:   {r3, alu} = {1'b1, alu_sub};
            op_slt:     {r3, alu} = {1'b1, alu_slt};
            op_sltu:    {r3, alu} = {1'b1, alu_sltu};
            op_nor:     {r3, alu} = {1'b1, alu_nor};
            op_and:     {r3, alu} = {1'b1, alu_and};
            op_or:      {r3, alu} = {1'b1, alu_or};
            op_xor:     {r3, alu} = {1'b1, alu_xor};
            op_sll_w:   {r3, alu} = {1'b1, alu_sll};
            op_srl_w:   {r3, alu} = {1'b1, alu_srl};
            op_sra_w:   {r3, alu} = {1'b1, alu_sra};
            op_slli_w:  {sh, alu} = {1'b1, alu_sll};
            op_srli_w:  {sh, alu} = {1'b1, alu_srl};
            op_srai_w:  {sh, alu} = {1'b1, alu_sra};
            op_syscall: sys = 1'b1;
            op_break:   brk = 1'b1;
            default: ;
        endcase
        case (op10)
            op_addi_w: {si12, alu} = {1'b1, alu_add};
            op_slti:   {si12, alu} = {1'b1, alu_slt};
            op_sltui:  {si12, alu} = {1'b1, alu_sltu};
            op_andi:   {ui12, alu} = {1'b1, alu_and};
            op_ori:    {ui12, alu} = {1'b1, alu_or};
            op_xori:   {ui12, alu} = {1'b1, alu_xor};
            default: ;
        endcase
    end

    always_comb begin
        bnd      = '0;
        bnd.beq  = op6 == op_beq;
        bnd.bne  = op6 == op_bne;
        bnd.blt  = op6 == op_blt;
        bnd.bge  = op6 == op_bge;
        bnd.bltu = op6 == op_bltu;
        bnd.bgeu = op6 == op_bgeu;
        bnd.jirl = op6 == op_jirl;
        bnd.b    = op6 == op_b;
        bnd.bl   = op6 == op_bl;
        cond_br  = bnd.beq | bnd.bne | bnd.blt | bnd.bge | bnd.bltu | bnd.bgeu;
        hit = (|alu) | ld | st | lu12i | pcadd | cond_br | bnd.jirl | bnd.b | bnd.bl
            | sys | brk;

        // loads, stores and links all use the adder
        bnd.alu_op = lu12i ? alu_lui
                   : (ld | st | pcadd | bnd.jirl | bnd.bl) ? alu_add : alu;
        bnd.src1_is_pc   = pcadd | bnd.jirl | bnd.bl;
        bnd.src2_is_imm  = sh | si12 | ui12 | ld | st | lu12i | bnd.src1_is_pc;
        bnd.rf_we        = ~(st | cond_br | bnd.b | sys | brk | ~hit);
        bnd.mem_we       = st;
        bnd.res_from_mem = ld;
        bnd.mem_unsigned = ld & op10[3];
        bnd.mem_size     = (ld | st) ? mem_size_e'(op10[1:0]) : mem_word;  // width in low opcode bits
        bnd.rf_waddr     = bnd.bl ? reg_idx_t'(1) : inst.ri12.rd;
        bnd.excep_en     = valid & (sys | brk | ~hit);
        bnd.ecode        = brk ? ecode_brk : sys ? ecode_sys : hit ? ecode_none : ecode_ine;
    end

    assign dec.bundle  = bnd;
    assign dec.raddr1  = inst.ri12.rj;
    assign dec.raddr2  = (cond_br | st) ? inst.ri12.rd : inst.r3.rk;
    assign dec.need_r1 = valid & hit & ~(bnd.b | bnd.bl | lu12i | pcadd | sys | brk);
    assign dec.need_r2 = valid & (r3 | cond_br | st);

    assign dec.imm = (bnd.jirl | bnd.bl)     ? `ID_XLEN'(4)
                   : (lu12i | pcadd)         ? {si20, 12'b0}
                   : (si12 | sh | ld | st)   ? {{(`ID_XLEN-12){inst.ri12.imm[11]}}, inst.ri12.imm}
                   : {{(`ID_XLEN-12){1'b0}}, inst.ri12.imm};

    assign dec.offs = (bnd.b | bnd.bl) ? {{(`ID_XLEN-28){si26[25]}}, si26, 2'b00}
                                       : {{(`ID_XLEN-18){si16[15]}}, si16, 2'b00};
endmodule

// ==== logic/id_ifaces.sv ====
`include "id_cfg.svh"

interface decode_if;
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_idx_t            raddr1;
    reg_idx_t            raddr2;
    logic                need_r1;
    logic                need_r2;
    logic [`ID_XLEN-1:0] imm;
    logic [`ID_XLEN-1:0] offs;  // pc-relative branch offset
    dec_bundle_t         bundle;

    modport dec (output raddr1, raddr2, need_r1, need_r2, imm, offs, bundle);
    modport fwd (input raddr1, raddr2, need_r1, need_r2);
    modport iss (input imm, offs, bundle);
endinterface

interface operand_if;
    logic [`ID_XLEN-1:0] rj_value;
    logic [`ID_XLEN-1:0] rkd_value;
    logic                stall;  // load result not ready yet

    modport fwd (output rj_value, rkd_value, stall);
    modport iss (input rj_value, rkd_value, stall);
endinterface

// ==== logic/id_issue.sv ====
`include "id_cfg.svh"

module id_issue (
    input  isa_pkg::inst_u      inst,
    input  logic [`ID_XLEN-1:0] pc,
    input  logic                valid,
    decode_if.iss               dec,
    operand_if.iss              opnd,
    input  logic                ex_allowin,
    input  logic                flush,
    output logic                allowin,
    output logic                ex_valid,
    output pipe_pkg::alu_op_t   ex_alu_op,
    output logic [`ID_XLEN-1:0] ex_alu_src1,
    output logic [`ID_XLEN-1:0] ex_alu_src2,
    output logic [`ID_XLEN-1:0] ex_rkd_value,
    output logic [`ID_XLEN-1:0] ex_pc,
    output logic                ex_rf_we,
    output isa_pkg::reg_idx_t   ex_rf_waddr,
    output logic                ex_mem_we,
    output logic                ex_res_from_mem,
    output pipe_pkg::mem_size_e ex_mem_size,
    output logic                ex_mem_unsigned,
    output logic                ex_excep_en,
    output pipe_pkg::ecode_e    ex_ecode,
    output logic                br_taken,
    output logic [`ID_XLEN-1:0] br_target,
    output logic                br_stall
);
    import pipe_pkg::*;

    dec_bundle_t         bnd;
    logic [`ID_XLEN-1:0] rj, rkd, jirl_offs;
    logic                eq, lt, ltu, cond, any_br, ready_go;

    assign bnd       = dec.bundle;
    assign rj        = opnd.rj_value;
    assign rkd       = opnd.rkd_value;
    assign ready_go  = ~opnd.stall;
    // si16 of jirl, the decoded imm holds the link step
    assign jirl_offs = {{(`ID_XLEN-18){inst.ri12.op[3]}}, inst.ri12.op[3:0], inst.ri12.imm, 2'b00};

    assign eq     = rj == rkd;
    assign lt     = $signed(rj) < $signed(rkd);
    assign ltu    = rj < rkd;
    assign any_br = bnd.beq | bnd.bne | bnd.blt | bnd.bge | bnd.bltu | bnd.bgeu
                  | bnd.jirl | bnd.b | bnd.bl;
    assign cond   = (bnd.beq & eq) | (bnd.bne & ~eq) | (bnd.blt & lt) | (bnd.bge & ~lt)
                  | (bnd.bltu & ltu) | (bnd.bgeu & ~ltu) | bnd.jirl | bnd.b | bnd.bl;

    assign br_taken  = cond & valid & ready_go & ex_allowin;
    assign br_target = bnd.jirl ? rj + jirl_offs : pc + dec.offs;
    assign br_stall  = any_br & valid & opnd.stall;  // fetch must hold its pc

    assign ex_valid = valid & ready_go;
    assign allowin  = ~valid | (ex_valid & ex_allowin) | br_taken | flush;

    assign ex_alu_op       = bnd.alu_op;
    assign ex_alu_src1     = bnd.src1_is_pc ? pc : rj;
    assign ex_alu_src2     = bnd.src2_is_imm ? dec.imm : rkd;
    assign ex_rkd_value    = rkd;  // store data
    assign ex_pc           = pc;
    assign ex_rf_we        = bnd.rf_we & valid;
    assign ex_rf_waddr     = bnd.rf_waddr;
    assign ex_mem_we       = bnd.mem_we & valid;
    assign ex_res_from_mem = bnd.res_from_mem;
    assign ex_mem_size     = bnd.mem_size;
    assign ex_mem_unsigned = bnd.mem_unsigned;
    assign ex_excep_en     = bnd.excep_en;
    assign ex_ecode        = bnd.ecode;
endmodule

// ==== logic/id_latch.sv ====
`include "id_cfg.svh"

module id_latch (
    input  logic                clk,
    input  logic                resetn,
    input  logic                if_valid,
    input  logic [`ID_XLEN-1:0] if_inst,
    input  logic [`ID_XLEN-1:0] if_pc,
    input  logic                allowin,
    input  logic                kill,
    output isa_pkg::inst_u      inst,
    output logic [`ID_XLEN-1:0] pc,
    output logic                valid
);
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (kill) begin
            valid <= 1'b0;  // fetched word is wrong path
        end else if (allowin) begin
            valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && allowin) begin
            inst <= if_inst;
            pc   <= if_pc;
        end
    end
endmodule

// ==== logic/id_operand_fwd.sv ====
`include "id_cfg.svh"

module id_operand_fwd (
    input  logic                clk,
    input  logic                exf_we,
    input  isa_pkg::reg_idx_t   exf_waddr,
    input  logic [`ID_XLEN-1:0] exf_wdata,
    input  logic                exf_is_load,
    input  logic                memf_we,
    input  isa_pkg::reg_idx_t   memf_waddr,
    input  logic [`ID_XLEN-1:0] memf_wdata,
    input  logic                memf_is_load,
    input  logic                wb_we,
    input  isa_pkg::reg_idx_t   wb_waddr,
    input  logic [`ID_XLEN-1:0] wb_wdata,
    decode_if.fwd               dec,
    operand_if.fwd              opnd
);
    import isa_pkg::*;

    logic [`ID_XLEN-1:0] regs [`ID_NREGS];
    reg_idx_t            ra [2];
    logic [`ID_XLEN-1:0] val [2];
    logic [1:0]          need;
    logic [1:0]          load_hit;

    always_ff @(posedge clk) begin
        if (wb_we) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

    assign ra[0] = dec.raddr1;
    assign ra[1] = dec.raddr2;
    assign need  = {dec.need_r2, dec.need_r1};

    for (genvar p = 0; p < 2; p++) begin : g_port
        logic zero, m_ex, m_mem, m_wb;

        assign zero  = ra[p] == '0;
        assign m_ex  = need[p] & ~zero & exf_we & (exf_waddr == ra[p]);
        assign m_mem = need[p] & ~zero & memf_we & (memf_waddr == ra[p]);
        assign m_wb  = need[p] & ~zero & wb_we & (wb_waddr == ra[p]);

        // youngest producer wins
        assign val[p] = m_ex  ? exf_wdata
                      : m_mem ? memf_wdata
                      : m_wb  ? wb_wdata
                      : zero  ? '0 : regs[ra[p]];

        assign load_hit[p] = (m_ex & exf_is_load) | (m_mem & memf_is_load);
    end

    assign opnd.rj_value  = val[0];
    assign opnd.rkd_value = val[1];
    assign opnd.stall     = |load_hit;
endmodule

// ==== logic/id_stage.sv ====
`include "id_cfg.svh"

module id_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                if_valid,
    input  logic [`ID_XLEN-1:0] if_inst,
    input  logic [`ID_XLEN-1:0] if_pc,
    input  logic                ex_allowin,
    input  logic                flush,
    input  logic                exf_we,
    input  isa_pkg::reg_idx_t   exf_waddr,
    input  logic [`ID_XLEN-1:0] exf_wdata,
    input  logic                exf_is_load,
    input  logic                memf_we,
    input  isa_pkg::reg_idx_t   memf_waddr,
    input  logic [`ID_XLEN-1:0] memf_wdata,
    input  logic                memf_is_load,
    input  logic                wb_we,
    input  isa_pkg::reg_idx_t   wb_waddr,
    input  logic [`ID_XLEN-1:0] wb_wdata,
    output logic                id_allowin,
    output logic                ex_valid,
    output pipe_pkg::alu_op_t   ex_alu_op,
    output logic [`ID_XLEN-1:0] ex_alu_src1,
    output logic [`ID_XLEN-1:0] ex_alu_src2,
    output logic [`ID_XLEN-1:0] ex_rkd_value,
    output logic [`ID_XLEN-1:0] ex_pc,
    output logic                ex_rf_we,
    output isa_pkg::reg_idx_t   ex_rf_waddr,
    output logic                ex_mem_we,
    output logic                ex_res_from_mem,
    output pipe_pkg::mem_size_e ex_mem_size,
    output logic                ex_mem_unsigned,
    output logic                ex_excep_en,
    output pipe_pkg::ecode_e    ex_ecode,
    output logic                br_taken,
    output logic [`ID_XLEN-1:0] br_target,
    output logic                br_stall
);
    import isa_pkg::*;

    inst_u               inst;
    logic [`ID_XLEN-1:0] pc;
    logic                valid;

    decode_if  dec_bus ();
    operand_if opnd_bus ();

    id_latch u_latch (
        .allowin (id_allowin),
        .kill    (br_taken | flush),  // stage empties behind a redirect
        .*
    );

    id_decoder u_decoder (
        .dec (dec_bus),
        .*
    );

    id_operand_fwd u_operand_fwd (
        .dec  (dec_bus),
        .opnd (opnd_bus),
        .*
    );

    id_issue u_issue (
        .dec     (dec_bus),
        .opnd    (opnd_bus),
        .allowin (id_allowin),
        .*
    );
endmodule

// ==== logic/isa_pkg.sv ====
`include "id_cfg.svh"

package isa_pkg;

    typedef logic [`ID_RIDX_W-1:0] reg_idx_t;

    typedef struct packed {
        logic [16:0] op;
        reg_idx_t    rk;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } r3_fmt_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] imm;
        reg_idx_t    rj;
        reg_idx_t    rd;
    } ri12_fmt_t;

    typedef union packed {
        r3_fmt_t   r3;
        ri12_fmt_t ri12;
    } inst_u;

    // inst[31:15]
    localparam logic [16:0] op_add_w   = 17'h00020;
    localparam logic [16:0] op_sub_w   = 17'h00022;
    localparam logic [16:0] op_slt     = 17'h00024;
    localparam logic [16:0] op_sltu    = 17'h00025;
    localparam logic [16:0] op_nor     = 17'h00028;
    localparam logic [16:0] op_and     = 17'h00029;
    localparam logic [16:0] op_or      = 17'h0002a;
    localparam logic [16:0] op_xor     = 17'h0002b;
    localparam logic [16:0] op_sll_w   = 17'h0002e;
    localparam logic [16:0] op_srl_w   = 17'h0002f;
    localparam logic [16:0] op_sra_w   = 17'h00030;
    localparam logic [16:0] op_break   = 17'h00054;
    localparam logic [16:0] op_syscall = 17'h00056;
    localparam logic [16:0] op_slli_w  = 17'h00081;  // ui5 sits in rk
    localparam logic [16:0] op_srli_w  = 17'h00089;
    localparam logic [16:0] op_srai_w  = 17'h00091;

    // inst[31:22]
    localparam logic [9:0] op_slti   = 10'h008;
    localparam logic [9:0] op_sltui  = 10'h009;
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_andi   = 10'h00d;
    localparam logic [9:0] op_ori    = 10'h00e;
    localparam logic [9:0] op_xori   = 10'h00f;
    localparam logic [9:0] op_ld_b   = 10'h0a0;
    localparam logic [9:0] op_ld_h   = 10'h0a1;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_b   = 10'h0a4;
    localparam logic [9:0] op_st_h   = 10'h0a5;
    localparam logic [9:0] op_st_w   = 10'h0a6;
    localparam logic [9:0] op_ld_bu  = 10'h0a8;
    localparam logic [9:0] op_ld_hu  = 10'h0a9;

    // inst[31:26], branches and jumps
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;
    localparam logic [5:0] op_blt  = 6'h18;
    localparam logic [5:0] op_bge  = 6'h19;
    localparam logic [5:0] op_bltu = 6'h1a;
    localparam logic [5:0] op_bgeu = 6'h1b;

    // inst[31:25], si20 forms
    localparam logic [6:0] op_lu12i_w   = 7'h0a;
    localparam logic [6:0] op_pcaddu12i = 7'h0e;

endpackage

// ==== logic/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    typedef logic [11:0] alu_op_t;

    localparam alu_op_t alu_add  = 12'h001;
    localparam alu_op_t alu_sub  = 12'h002;
    localparam alu_op_t alu_slt  = 12'h004;
    localparam alu_op_t alu_sltu = 12'h008;
    localparam alu_op_t alu_and  = 12'h010;
    localparam alu_op_t alu_nor  = 12'h020;
    localparam alu_op_t alu_or   = 12'h040;
    localparam alu_op_t alu_xor  = 12'h080;
    localparam alu_op_t alu_sll  = 12'h100;
    localparam alu_op_t alu_srl  = 12'h200;
    localparam alu_op_t alu_sra  = 12'h400;
    localparam alu_op_t alu_lui  = 12'h800;

    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_e;

    typedef enum logic [5:0] {
        ecode_none = 6'h00,
        ecode_sys  = 6'h0b,
        ecode_brk  = 6'h0c,
        ecode_ine  = 6'h0d
    } ecode_e;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      rf_we;
        logic      mem_we;
        logic      res_from_mem;
        logic      mem_unsigned;
        mem_size_e mem_size;
        reg_idx_t  rf_waddr;
        logic      beq, bne, blt, bge, bltu, bgeu;  // conditional, compare rj with rd
        logic      jirl, b, bl;
        logic      excep_en;
        ecode_e    ecode;
    } dec_bundle_t;

endpackage

// ==== tb.f ====
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/id_ifaces.sv
logic/id_latch.sv
logic/id_decoder.sv
logic/id_operand_fwd.sv
logic/id_issue.sv
logic/id_stage.sv
verification/id_stage_asserts.sv
verification/id_stage_tb.sv

// ==== verification/id_stage_asserts.sv ====
`include "id_cfg.svh"

module id_stage_asserts (
    input logic                clk,
    input logic                resetn,
    input logic                ex_valid,
    input logic                ex_allowin,
    input logic                flush,
    input logic                br_taken,
    input logic                br_stall,
    input logic                ex_rf_we,
    input logic                ex_mem_we,
    input logic [`ID_XLEN-1:0] ex_pc,
    input pipe_pkg::alu_op_t   ex_alu_op
);
    timeunit 1ns;
    timeprecision 100ps;

    reset_empties_stage: assert property (@(posedge clk)
        !resetn |=> !ex_valid && !br_taken && !br_stall && !ex_rf_we && !ex_mem_we)
        else $error("control output high after a reset edge");

    redirect_empties_stage: assert property (@(posedge clk) disable iff (!resetn)
        br_taken || flush |=> !ex_valid) else $error("wrong-path word issued after a redirect");

    stall_holds_branch: assert property (@(posedge clk) disable iff (!resetn)
        br_stall && !flush |=> br_stall || ex_valid) else $error("stalled branch left the stage");

    // stage keeps its word while ex pushes back
    hold_on_backpressure: assert property (@(posedge clk) disable iff (!resetn)
        ex_valid && !ex_allowin && !flush |=> $stable(ex_pc) && $stable(ex_alu_op))
        else $error("ex outputs changed while ex was blocked");
endmodule

bind id_stage id_stage_asserts asserts_i (.*);

// ==== verification/id_stage_tb.sv ====
`include "id_cfg.svh"

module id_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                clk, resetn, if_valid, ex_allowin, flush;
    logic                exf_we, exf_is_load, memf_we, memf_is_load, wb_we;
    logic [`ID_XLEN-1:0] if_inst, if_pc, exf_wdata, memf_wdata, wb_wdata;
    reg_idx_t            exf_waddr, memf_waddr, wb_waddr, ex_rf_waddr;
    logic                id_allowin, ex_valid, ex_rf_we, ex_mem_we, ex_res_from_mem;
    logic                ex_mem_unsigned, ex_excep_en, br_taken, br_stall;
    logic [`ID_XLEN-1:0] ex_alu_src1, ex_alu_src2, ex_rkd_value, ex_pc, br_target;
    alu_op_t             ex_alu_op;
    mem_size_e           ex_mem_size;
    ecode_e              ex_ecode;
    logic [31:0]         seed = 32'h4b19;
    int                  n_err = 0;
    int                  n_timeout = 0;

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic report_mismatch(input string name, input logic [`ID_XLEN-1:0] got, exp);
        $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        n_err++;
    endtask

    task automatic check_word(input string name, input logic [`ID_XLEN-1:0] got, exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_alu_op(input string name, input alu_op_t got, exp);
        if (got !== exp) report_mismatch(name, `ID_XLEN'(got), `ID_XLEN'(exp));
    endtask

    task automatic check_ecode(input string name, input ecode_e got, exp);
        if (got !== exp) report_mismatch(name, `ID_XLEN'(got), `ID_XLEN'(exp));
    endtask

    task automatic check_mem_size(input string name, input mem_size_e got, exp);
        if (got !== exp) report_mismatch(name, `ID_XLEN'(got), `ID_XLEN'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) report_mismatch(name, `ID_XLEN'(got), `ID_XLEN'(exp));
    endtask

    function automatic logic [31:0] r3_word(logic [16:0] op, reg_idx_t rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_word(logic [9:0] op, logic [11:0] imm,
                                              reg_idx_t rj, rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] br16_word(logic [5:0] op, logic [15:0] offs,
                                              reg_idx_t rj, rd);
        return {op, offs, rj, rd};
    endfunction

    task automatic write_reg(input reg_idx_t r, input logic [31:0] v);
        wb_we    = 1'b1;
        wb_waddr = r;
        wb_wdata = v;
        step();
        wb_we = 1'b0;
    endtask

    // word sits in decode once this returns
    task automatic issue_word(input logic [31:0] word, input logic [31:0] pc);
        int n = 0;
        while (!id_allowin && n < 50) begin
            step();
            n++;
        end
        if (!id_allowin) begin
            $display("timeout: decode stage did not accept an instruction");
            n_timeout++;
        end
        if_valid = 1'b1;
        if_inst  = word;
        if_pc    = pc;
        step();
        if_valid = 1'b0;
    endtask

    task automatic reg_reg_ops();
        logic [16:0] ops [4] = '{op_add_w, op_sub_w, op_sltu, op_sra_w};
        int          bits [4] = '{0, 1, 3, 10};  // one-hot position
        logic [31:0] a, b;
        a = next_rand();
        b = next_rand();
        write_reg(5'd4, a);
        write_reg(5'd5, b);
        for (int i = 0; i < 4; i++) begin
            issue_word(r3_word(ops[i], 5'd5, 5'd4, 5'd7), 32'h1c00_0000);
            check_alu_op("ex_alu_op", ex_alu_op, alu_op_t'(1) << bits[i]);
            check_word("ex_alu_src1", ex_alu_src1, a);
            check_word("ex_alu_src2", ex_alu_src2, b);
            check_word("ex_rkd_value", ex_rkd_value, b);
            check_word("ex_rf_waddr", `ID_XLEN'(ex_rf_waddr), 32'd7);
            check_bit("ex_rf_we", ex_rf_we, 1'b1);
        end
    endtask

    task automatic immediate_forms();
        logic [31:0] base, pc;
        base = next_rand();
        pc   = 32'h1c00_0100;
        write_reg(5'd6, base);
        issue_word(ri12_word(op_addi_w, 12'hff0, 5'd6, 5'd8), pc);
        check_alu_op("ex_alu_op", ex_alu_op, 12'h001);
        check_word("ex_alu_src1", ex_alu_src1, base);
        check_word("ex_alu_src2", ex_alu_src2, 32'hffff_fff0);
        issue_word(ri12_word(op_andi, 12'h8a5, 5'd6, 5'd8), pc);
        check_alu_op("ex_alu_op", ex_alu_op, 12'h010);
        check_word("ex_alu_src2", ex_alu_src2, 32'h0000_08a5);
        issue_word(r3_word(op_slli_w, 5'd7, 5'd6, 5'd8), pc);
        check_alu_op("ex_alu_op", ex_alu_op, 12'h100);
        check_word("ex_alu_src2[4:0]", `ID_XLEN'(ex_alu_src2[4:0]), 32'd7);  // shift amount
        issue_word({op_lu12i_w, 20'h81234, 5'd9}, pc);
        check_alu_op("ex_alu_op", ex_alu_op, 12'h800);
        check_word("ex_alu_src2", ex_alu_src2, 32'h8123_4000);
        issue_word({op_pcaddu12i, 20'h00003, 5'd9}, pc);
        check_word("ex_alu_src1", ex_alu_src1, pc);
        check_word("ex_alu_src2", ex_alu_src2, 32'h0000_3000);
        issue_word(ri12_word(op_ld_hu, 12'h7fc, 5'd6, 5'd8), pc);
        check_word("ex_alu_src2", ex_alu_src2, 32'h0000_07fc);
        check_bit("ex_res_from_mem", ex_res_from_mem, 1'b1);
        check_bit("ex_mem_unsigned", ex_mem_unsigned, 1'b1);
        check_mem_size("ex_mem_size", ex_mem_size, mem_half);
        issue_word(ri12_word(op_st_b, 12'h804, 5'd6, 5'd6), pc);  // data from rd
        check_word("ex_alu_src2", ex_alu_src2, 32'hffff_f804);
        check_word("ex_rkd_value", ex_rkd_value, base);
        check_bit("ex_mem_we", ex_mem_we, 1'b1);
        check_bit("ex_rf_we", ex_rf_we, 1'b0);
        check_mem_size("ex_mem_size", ex_mem_size, mem_byte);
    endtask

    task automatic forwarding_order();
        logic [31:0] v_ex, v_mem, v_wb;
        v_ex  = next_rand();
        v_mem = next_rand();
        v_wb  = next_rand();
        {exf_we, exf_waddr, exf_wdata}    = {1'b1, 5'd9, v_ex};
        {memf_we, memf_waddr, memf_wdata} = {1'b1, 5'd9, v_mem};
        {wb_we, wb_waddr, wb_wdata}       = {1'b1, 5'd9, v_wb};
        issue_word(r3_word(op_add_w, 5'd0, 5'd9, 5'd10), 32'h1c00_0200);
        wb_wdata = ~v_wb;  // forwarded word differs from the one written
        check_word("ex_alu_src1", ex_alu_src1, v_ex);
        check_word("ex_alu_src2", ex_alu_src2, 32'd0);  // r0
        exf_we = 1'b0;
        #1 check_word("ex_alu_src1", ex_alu_src1, v_mem);
        memf_we = 1'b0;
        #1 check_word("ex_alu_src1", ex_alu_src1, ~v_wb);
        wb_we = 1'b0;
        #1 check_word("ex_alu_src1", ex_alu_src1, v_wb);  // written at the issue edge
    endtask

    task automatic load_use_stall();
        logic [31:0] pc, v;
        int          n = 0;
        pc = 32'h1c00_0300;
        v  = next_rand();
        write_reg(5'd12, v);
        {exf_we, exf_waddr, exf_is_load} = {1'b1, 5'd11, 1'b1};
        issue_word(br16_word(op_beq, 16'h0010, 5'd11, 5'd12), pc);
        check_bit("ex_valid", ex_valid, 1'b0);
        check_bit("id_allowin", id_allowin, 1'b0);
        check_bit("br_stall", br_stall, 1'b1);
        check_bit("br_taken", br_taken, 1'b0);
        step();
        {exf_we, exf_is_load} = 2'b00;  // load now in mem, data not back yet
        {memf_we, memf_waddr, memf_wdata, memf_is_load} = {1'b1, 5'd11, v, 1'b1};
        #1 check_bit("ex_valid", ex_valid, 1'b0);
        step();
        memf_is_load = 1'b0;
        #1;
        while (!ex_valid && n < 50) begin
            step();
            n++;
        end
        if (!ex_valid) begin
            $display("timeout: stalled branch never issued after the load returned");
            n_timeout++;
        end
        check_bit("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, pc + 32'h40);
        step();
        memf_we = 1'b0;
        check_bit("ex_valid", ex_valid, 1'b0);
        ex_allowin = 1'b0;
        issue_word(ri12_word(op_ori, 12'h123, 5'd12, 5'd13), pc + 32'h40);
        repeat (3) step();
        check_bit("id_allowin", id_allowin, 1'b0);
        check_bit("ex_valid", ex_valid, 1'b1);
        check_word("ex_alu_src1", ex_alu_src1, v);
        check_word("ex_alu_src2", ex_alu_src2, 32'h0000_0123);
        check_word("ex_pc", ex_pc, pc + 32'h40);
        ex_allowin = 1'b1;
        step();
    endtask

    task automatic branch_resolve();
        logic [31:0] pc;
        pc = 32'h1c00_0400;
        write_reg(5'd13, 32'd5);
        write_reg(5'd14, 32'hffff_fffd);
        issue_word(br16_word(op_beq, 16'h0008, 5'd13, 5'd14), pc);
        check_bit("br_taken", br_taken, 1'b0);
        issue_word(br16_word(op_bltu, 16'hfff8, 5'd14, 5'd13), pc);
        check_bit("br_taken", br_taken, 1'b0);
        issue_word(br16_word(op_bltu, 16'hfff8, 5'd13, 5'd14), pc);
        check_bit("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, pc - 32'd32);
        step();
        check_bit("ex_valid", ex_valid, 1'b0);  // wrong-path slot dropped
        issue_word({op_bl, 16'h0010, 10'h000}, pc);
        check_bit("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, pc + 32'h40);
        check_word("ex_rf_waddr", `ID_XLEN'(ex_rf_waddr), 32'd1);
        check_word("ex_alu_src2", ex_alu_src2, 32'd4);
        step();
        issue_word(br16_word(op_jirl, 16'h0004, 5'd13, 5'd1), pc);
        check_bit("br_taken", br_taken, 1'b1);
        check_word("br_target", br_target, 32'd5 + 32'd16);
        step();
    endtask

    task automatic exception_codes();
        logic [31:0] words [3] = '{32'hffff_ffff, {op_syscall, 15'h0}, {op_break, 15'h0}};
        ecode_e      codes [3] = '{ecode_e'(6'h0d), ecode_e'(6'h0b), ecode_e'(6'h0c)};
        for (int i = 0; i < 3; i++) begin
            issue_word(words[i], 32'h1c00_0500);
            check_bit("ex_excep_en", ex_excep_en, 1'b1);
            check_bit("ex_rf_we", ex_rf_we, 1'b0);
            check_ecode("ex_ecode", ex_ecode, codes[i]);
        end
        step();
    endtask

    initial begin
        {resetn, if_valid, flush, ex_allowin} = 4'b0001;
        {exf_we, exf_is_load, memf_we, memf_is_load, wb_we} = '0;
        {if_inst, if_pc, exf_wdata, memf_wdata, wb_wdata} = '0;
        {exf_waddr, memf_waddr, wb_waddr} = '0;
        repeat (8) @(posedge clk);
        #1 resetn = 1'b1;
        check_bit("ex_valid", ex_valid, 1'b0);
        check_bit("br_taken", br_taken, 1'b0);
        check_bit("br_stall", br_stall, 1'b0);
        check_bit("ex_rf_we", ex_rf_we, 1'b0);
        check_bit("ex_mem_we", ex_mem_we, 1'b0);
        reg_reg_ops();
        immediate_forms();
        forwarding_order();
        load_use_stall();
        branch_resolve();
        exception_codes();
        $display("errors: %0d mismatches, %0d timeouts", n_err, n_timeout);
        if (n_err == 0 && n_timeout == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule
